/* hw/ll_pkg.sv */
`default_nettype none

package ll_pkg;

  // default sizes, the top level passes its own values down
  localparam int NUM_LISTS  = 4;
  localparam int NUM_NODES  = 16;
  localparam int DATA_WIDTH = 16;

  localparam int LIST_W = (NUM_LISTS > 1) ? $clog2(NUM_LISTS) : 1;
  localparam int PTR_W  = (NUM_NODES > 1) ? $clog2(NUM_NODES) : 1;
  // count must reach NUM_NODES itself
  localparam int CNT_W  = $clog2(NUM_NODES + 1);

  typedef enum logic [2:0] {
    op_add_head,
    op_add_tail,
    op_del_head,
    op_read_pos,
    op_read_count,
    op_read_total
  } ll_op_e;

  typedef enum logic [1:0] {
    st_ok,
    st_empty,
    st_full,
    st_bad_pos
  } ll_status_e;

  typedef enum logic [2:0] {
    s_idle,
    s_check,
    s_alloc,
    s_walk,
    s_link,
    s_release,
    s_resp
  } ll_state_e;

endpackage

`default_nettype wire

/* hw/ll_node_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_node_mem import ll_pkg::*; #(
  parameter int NUM_NODES  = ll_pkg::NUM_NODES,
  parameter int DATA_WIDTH = ll_pkg::DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic                  wr_link_only,
  input  logic [PTR_W-1:0]      wr_addr,
  input  logic [PTR_W-1:0]      wr_next,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_en,
  input  logic [PTR_W-1:0]      rd_addr,
  output logic [PTR_W-1:0]      rd_next,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] data_mem [NUM_NODES];
  logic [PTR_W-1:0]      next_mem [NUM_NODES];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      next_mem[wr_addr] <= wr_next;
      // link update touches the pointer only
      if (!wr_link_only) begin
        data_mem[wr_addr] <= wr_data;
      end
    end
    // read data holds until the next read
    if (rd_en) begin
      rd_next <= next_mem[rd_addr];
      rd_data <= data_mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* hw/ll_free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_free_list import ll_pkg::*; #(
  parameter int NUM_NODES = ll_pkg::NUM_NODES
) (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             alloc,
  input  logic             release_en,
  input  logic [PTR_W-1:0] release_ptr,
  output logic [PTR_W-1:0] free_ptr,
  output logic             free_empty
);

  logic [PTR_W-1:0] free_q [NUM_NODES];
  logic [PTR_W-1:0] rd_idx;
  logic [PTR_W-1:0] wr_idx;
  logic [CNT_W-1:0] occupancy;

  // step an index round the queue
  function automatic logic [PTR_W-1:0] next_idx(input logic [PTR_W-1:0] idx);
    if (idx == PTR_W'(NUM_NODES - 1)) begin
      return '0;
    end
    return idx + PTR_W'(1);
  endfunction

  assign free_ptr   = free_q[rd_idx];
  assign free_empty = (occupancy == '0);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      // every node free, lowest index handed out first
      for (int i = 0; i < NUM_NODES; i++) begin
        free_q[i] <= PTR_W'(i);
      end
      rd_idx    <= '0;
      wr_idx    <= '0;
      occupancy <= CNT_W'(NUM_NODES);
    end else begin
      if (alloc && !free_empty) begin
        rd_idx <= next_idx(rd_idx);
      end
      if (release_en) begin
        free_q[wr_idx] <= release_ptr;
        wr_idx         <= next_idx(wr_idx);
      end
      if (release_en && !(alloc && !free_empty)) begin
        occupancy <= occupancy + CNT_W'(1);
      end else if (!release_en && alloc && !free_empty) begin
        occupancy <= occupancy - CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/ll_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_walker import ll_pkg::*; #(
  parameter int DATA_WIDTH = ll_pkg::DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  walk_start,
  input  logic [PTR_W-1:0]      walk_ptr,
  input  logic [CNT_W-1:0]      walk_steps,
  input  logic [PTR_W-1:0]      rd_next,
  input  logic [DATA_WIDTH-1:0] rd_data,
  output logic                  rd_en,
  output logic [PTR_W-1:0]      rd_addr,
  output logic                  walk_done,
  output logic [PTR_W-1:0]      found_ptr,
  output logic [PTR_W-1:0]      found_next,
  output logic [DATA_WIDTH-1:0] found_data
);

  logic             issue_first;
  logic             rd_pending;
  logic [PTR_W-1:0] cur_ptr;
  logic [CNT_W-1:0] steps_left;
  logic             more_steps;

  // cur_ptr always names the node whose read is in flight
  assign more_steps = rd_pending & (steps_left != '0);
  assign rd_en      = issue_first | more_steps;
  assign rd_addr    = issue_first ? cur_ptr : rd_next;
  assign walk_done  = rd_pending & (steps_left == '0);

  // memory output stays put once the walk ends
  assign found_ptr  = cur_ptr;
  assign found_next = rd_next;
  assign found_data = rd_data;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      issue_first <= 1'b0;
      rd_pending  <= 1'b0;
    end else begin
      issue_first <= walk_start;
      rd_pending  <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (walk_start) begin
      cur_ptr    <= walk_ptr;
      steps_left <= walk_steps;
    end else if (more_steps) begin
      // follow the pointer just returned
      cur_ptr    <= rd_next;
      steps_left <= steps_left - CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

/* hw/ll_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_ctrl_fsm import ll_pkg::*; #(
  parameter int NUM_LISTS  = ll_pkg::NUM_LISTS,
  parameter int DATA_WIDTH = ll_pkg::DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  cmd_valid,
  input  ll_op_e                cmd_op,
  input  logic [LIST_W-1:0]     cmd_list,
  input  logic [CNT_W-1:0]      cmd_pos,
  input  logic [DATA_WIDTH-1:0] cmd_data,
  output logic                  idle,
  output logic                  resp_valid,
  output ll_status_e            resp_status,
  output logic [DATA_WIDTH-1:0] resp_data,
  input  logic [PTR_W-1:0]      free_ptr,
  input  logic                  free_empty,
  output logic                  alloc,
  output logic                  release_en,
  output logic [PTR_W-1:0]      release_ptr,
  output logic                  walk_start,
  output logic [PTR_W-1:0]      walk_ptr,
  output logic [CNT_W-1:0]      walk_steps,
  input  logic                  walk_done,
  input  logic [PTR_W-1:0]      found_ptr,
  input  logic [PTR_W-1:0]      found_next,
  input  logic [DATA_WIDTH-1:0] found_data,
  output logic                  wr_en,
  output logic                  wr_link_only,
  output logic [PTR_W-1:0]      wr_addr,
  output logic [PTR_W-1:0]      wr_next,
  output logic [DATA_WIDTH-1:0] wr_data
);

  ll_state_e             state;
  ll_state_e             state_nxt;

  // latched command
  ll_op_e                op_q;
  logic [LIST_W-1:0]     list_q;
  logic [CNT_W-1:0]      pos_q;
  logic [DATA_WIDTH-1:0] data_q;

  logic [PTR_W-1:0]      head_tbl [NUM_LISTS];
  logic [CNT_W-1:0]      count_tbl [NUM_LISTS];
  logic [CNT_W-1:0]      total;
  logic [CNT_W-1:0]      cnt_cur;
  logic [PTR_W-1:0]      new_ptr_q;
  ll_status_e            status_q;
  logic [DATA_WIDTH-1:0] result_q;

  assign cnt_cur = count_tbl[list_q];

  // busy until the response strobe has gone
  assign idle = (state == s_idle) & ~resp_valid;

  always_comb begin
    state_nxt    = state;
    alloc        = 1'b0;
    release_en   = 1'b0;
    release_ptr  = found_ptr;
    walk_start   = 1'b0;
    walk_ptr     = head_tbl[list_q];
    walk_steps   = pos_q;
    wr_en        = 1'b0;
    wr_link_only = 1'b0;
    wr_addr      = free_ptr;
    wr_next      = head_tbl[list_q];
    wr_data      = data_q;
    case (state)
      s_idle: begin
        if (cmd_valid) begin
          state_nxt = s_check;
        end
      end
      s_check: begin
        // errors and register reads go straight to the response
        state_nxt = s_resp;
        case (op_q)
          op_add_head, op_add_tail: begin
            if (!free_empty) begin
              state_nxt = s_alloc;
            end
          end
          op_del_head: begin
            if (cnt_cur != '0) begin
              walk_start = 1'b1;
              walk_steps = '0;
              state_nxt  = s_walk;
            end
          end
          op_read_pos: begin
            if (cnt_cur != '0 && pos_q < cnt_cur) begin
              walk_start = 1'b1;
              state_nxt  = s_walk;
            end
          end
          default: begin
            state_nxt = s_resp;
          end
        endcase
      end
      s_alloc: begin
        alloc     = 1'b1;
        wr_en     = 1'b1;
        state_nxt = s_resp;
        // tail of a non-empty list still has to be found
        if (op_q == op_add_tail && cnt_cur != '0) begin
          walk_start = 1'b1;
          walk_steps = cnt_cur - CNT_W'(1);
          state_nxt  = s_walk;
        end
      end
      s_walk: begin
        if (walk_done) begin
          case (op_q)
            op_del_head: state_nxt = s_release;
            op_add_tail: state_nxt = s_link;
            default:     state_nxt = s_resp;
          endcase
        end
      end
      s_link: begin
        wr_en        = 1'b1;
        wr_link_only = 1'b1;
        wr_addr      = found_ptr;
        wr_next      = new_ptr_q;
        state_nxt    = s_resp;
      end
      s_release: begin
        release_en = 1'b1;
        state_nxt  = s_idle;
      end
      s_resp: begin
        state_nxt = s_idle;
      end
      default: begin
        state_nxt = s_idle;
      end
    endcase
  end

  // state, counts and response strobe
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state      <= s_idle;
      resp_valid <= 1'b0;
      total      <= '0;
      for (int i = 0; i < NUM_LISTS; i++) begin
        count_tbl[i] <= '0;
      end
    end else begin
      state      <= state_nxt;
      resp_valid <= (state == s_resp) | (state == s_release);
      if ((state == s_alloc && (op_q == op_add_head || cnt_cur == '0)) ||
          state == s_link) begin
        count_tbl[list_q] <= cnt_cur + CNT_W'(1);
        total             <= total + CNT_W'(1);
      end else if (state == s_release) begin
        count_tbl[list_q] <= cnt_cur - CNT_W'(1);
        total             <= total - CNT_W'(1);
      end
    end
  end

  // command latch, head table and response payload
  always_ff @(posedge clk) begin
    case (state)
      s_idle: begin
        if (cmd_valid) begin
          op_q   <= cmd_op;
          list_q <= cmd_list;
          pos_q  <= cmd_pos;
          data_q <= cmd_data;
        end
      end
      s_check: begin
        status_q <= st_ok;
        result_q <= '0;
        case (op_q)
          op_add_head, op_add_tail: begin
            if (free_empty) status_q <= st_full;
          end
          op_del_head: begin
            if (cnt_cur == '0) status_q <= st_empty;
          end
          op_read_pos: begin
            if (cnt_cur == '0) status_q <= st_empty;
            else if (pos_q >= cnt_cur) status_q <= st_bad_pos;
          end
          op_read_count: result_q <= DATA_WIDTH'(cnt_cur);
          op_read_total: result_q <= DATA_WIDTH'(total);
          default: status_q <= st_ok;
        endcase
      end
      s_alloc: begin
        new_ptr_q <= free_ptr;
        if (op_q == op_add_head || cnt_cur == '0) begin
          head_tbl[list_q] <= free_ptr;
        end
      end
      s_walk: begin
        if (walk_done && op_q == op_read_pos) result_q <= found_data;
      end
      s_release: begin
        head_tbl[list_q] <= found_next;
        resp_status      <= st_ok;
        resp_data        <= found_data;
      end
      s_resp: begin
        resp_status <= status_q;
        resp_data   <= result_q;
      end
      default: begin
        result_q <= result_q;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/ll_mngr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_mngr_top import ll_pkg::*; #(
  parameter int NUM_LISTS  = ll_pkg::NUM_LISTS,
  parameter int NUM_NODES  = ll_pkg::NUM_NODES,
  parameter int DATA_WIDTH = ll_pkg::DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  cmd_valid,
  input  ll_op_e                cmd_op,
  input  logic [LIST_W-1:0]     cmd_list,
  input  logic [CNT_W-1:0]      cmd_pos,
  input  logic [DATA_WIDTH-1:0] cmd_data,
  output logic                  idle,
  output logic                  resp_valid,
  output ll_status_e            resp_status,
  output logic [DATA_WIDTH-1:0] resp_data
);

  // free list side
  logic                  alloc;
  logic                  release_en;
  logic [PTR_W-1:0]      release_ptr;
  logic [PTR_W-1:0]      free_ptr;
  logic                  free_empty;

  // walker side
  logic                  walk_start;
  logic [PTR_W-1:0]      walk_ptr;
  logic [CNT_W-1:0]      walk_steps;
  logic                  walk_done;
  logic [PTR_W-1:0]      found_ptr;
  logic [PTR_W-1:0]      found_next;
  logic [DATA_WIDTH-1:0] found_data;

  // node memory ports
  logic                  wr_en;
  logic                  wr_link_only;
  logic [PTR_W-1:0]      wr_addr;
  logic [PTR_W-1:0]      wr_next;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_en;
  logic [PTR_W-1:0]      rd_addr;
  logic [PTR_W-1:0]      rd_next;
  logic [DATA_WIDTH-1:0] rd_data;

  ll_ctrl_fsm #(
    .NUM_LISTS  (NUM_LISTS),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_ctrl_fsm (
    .clk, .reset_n,
    .cmd_valid, .cmd_op, .cmd_list, .cmd_pos, .cmd_data,
    .idle, .resp_valid, .resp_status, .resp_data,
    .free_ptr, .free_empty, .alloc, .release_en, .release_ptr,
    .walk_start, .walk_ptr, .walk_steps,
    .walk_done, .found_ptr, .found_next, .found_data,
    .wr_en, .wr_link_only, .wr_addr, .wr_next, .wr_data
  );

  ll_free_list #(
    .NUM_NODES (NUM_NODES)
  ) u_free_list (
    .clk, .reset_n, .alloc, .release_en, .release_ptr, .free_ptr, .free_empty
  );

  ll_walker #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_walker (
    .clk, .reset_n, .walk_start, .walk_ptr, .walk_steps, .rd_next, .rd_data,
    .rd_en, .rd_addr, .walk_done, .found_ptr, .found_next, .found_data
  );

  ll_node_mem #(
    .NUM_NODES  (NUM_NODES),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_node_mem (
    .clk, .wr_en, .wr_link_only, .wr_addr, .wr_next, .wr_data,
    .rd_en, .rd_addr, .rd_next, .rd_data
  );

endmodule

`default_nettype wire

/* bench/ll_mngr_props.sv */
`timescale 1ns/1ps
`default_nettype none

module ll_mngr_props import ll_pkg::*; #(
  parameter int NUM_NODES = ll_pkg::NUM_NODES
) (
  input logic             clk,
  input logic             reset_n,
  input logic             cmd_valid,
  input logic             idle,
  input logic             resp_valid,
  input logic [CNT_W-1:0] total
);

  // one response strobe per command
  assert property (@(posedge clk) disable iff (!reset_n) resp_valid |=> !resp_valid)
    else $error("resp_valid high for two cycles in a row");

  // host may only strobe while idle
  assert property (@(posedge clk) disable iff (!reset_n) cmd_valid |-> idle)
    else $error("cmd_valid while idle is low");

  assert property (@(posedge clk) disable iff (!reset_n) total <= CNT_W'(NUM_NODES))
    else $error("total node count above NUM_NODES");

  assert property (@(posedge clk) disable iff (!reset_n) resp_valid |=> idle)
    else $error("idle low in the cycle after resp_valid");

endmodule

bind ll_mngr_top ll_mngr_props #(
  .NUM_NODES (NUM_NODES)
) props0 (
  .clk, .reset_n, .cmd_valid, .idle, .resp_valid,
  .total (u_ctrl_fsm.total)
);

`default_nettype wire

/* bench/tb_ll_mngr.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ll_mngr import ll_pkg::*; ;

  localparam int RESP_LIMIT = 100;
  localparam int CYCLES_PER_LINE = 100;

  logic                  clk;
  logic                  reset_n;
  logic                  cmd_valid;
  ll_op_e                cmd_op;
  logic [LIST_W-1:0]     cmd_list;
  logic [CNT_W-1:0]      cmd_pos;
  logic [DATA_WIDTH-1:0] cmd_data;
  logic                  idle;
  logic                  resp_valid;
  ll_status_e            resp_status;
  logic [DATA_WIDTH-1:0] resp_data;

  // trace columns, one entry per command
  int                    tr_test [$];
  int                    tr_op [$];
  int                    tr_list [$];
  int                    tr_pos [$];
  int                    tr_st [$];
  logic [DATA_WIDTH-1:0] tr_data [$];
  logic [DATA_WIDTH-1:0] tr_exp [$];

  int n_lines = 0;
  bit loaded = 1'b0;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  ll_mngr_top #(
    .NUM_LISTS  (NUM_LISTS),
    .NUM_NODES  (NUM_NODES),
    .DATA_WIDTH (DATA_WIDTH)
  ) dut0 (
    .clk, .reset_n,
    .cmd_valid, .cmd_op, .cmd_list, .cmd_pos, .cmd_data,
    .idle, .resp_valid, .resp_status, .resp_data
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic load_trace();
    int fd;
    int n;
    int t, o, l, p, s;
    logic [DATA_WIDTH-1:0] d;
    logic [DATA_WIDTH-1:0] e;
    string line;
    fd = $fopen("bench/ll_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open trace file bench/ll_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // comment lines do not scan as seven fields
        if (n > 0 && $sscanf(line, "%d %d %d %d %h %d %h", t, o, l, p, d, s, e) == 7) begin
          tr_test.push_back(t);
          tr_op.push_back(o);
          tr_list.push_back(l);
          tr_pos.push_back(p);
          tr_data.push_back(d);
          tr_st.push_back(s);
          tr_exp.push_back(e);
        end
      end
      $fclose(fd);
    end
    n_lines = tr_test.size();
    if (n_lines == 0) begin
      $display("trace file holds no commands");
      errors++;
    end
  endtask

  // one command: wait for idle, strobe it, wait for the response and check
  task automatic run_command(input int idx);
    int waited;
    ll_status_e exp_st;
    exp_st = ll_status_e'(2'(tr_st[idx]));
    @(negedge clk);
    while (!idle) @(negedge clk);
    cmd_valid = 1'b1;
    cmd_op    = ll_op_e'(3'(tr_op[idx]));
    cmd_list  = LIST_W'(tr_list[idx]);
    cmd_pos   = CNT_W'(tr_pos[idx]);
    cmd_data  = tr_data[idx];
    @(negedge clk);
    cmd_valid = 1'b0;
    // busy from the cycle after the strobe
    assert (!idle) else begin
      $display("mismatch at %0t: idle got %b expected %b", $time, idle, 1'b0);
      errors++;
    end
    waited = 0;
    while (!resp_valid && waited < RESP_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_valid) begin
      $display("no response to command %0d of test %0d within %0d cycles",
               idx, tr_test[idx], RESP_LIMIT);
      errors++;
    end else begin
      assert (resp_status == exp_st) else begin
        $display("mismatch at %0t: resp_status got %s expected %s",
                 $time, resp_status.name(), exp_st.name());
        errors++;
      end
      assert (resp_data == tr_exp[idx]) else begin
        $display("mismatch at %0t: resp_data got %h expected %h",
                 $time, resp_data, tr_exp[idx]);
        errors++;
      end
    end
  endtask

  task automatic report_test(input int test, input int cmds, input int errs);
    if (errs == 0) begin
      tests_passed++;
      $display("test %0d: %0d commands, ok", test, cmds);
    end else begin
      tests_failed++;
      $display("test %0d: %0d commands, %0d errors", test, cmds, errs);
    end
  endtask

  initial begin
    int cur_test;
    int test_cmds;
    int errs_at_start;
    cmd_valid = 1'b0;
    cmd_op    = op_add_head;
    cmd_list  = '0;
    cmd_pos   = '0;
    cmd_data  = '0;
    reset_n   = 1'b0;
    load_trace();
    loaded = 1'b1;
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    cur_test = -1;
    test_cmds = 0;
    errs_at_start = errors;
    for (int i = 0; i < n_lines; i++) begin
      if (tr_test[i] != cur_test) begin
        if (cur_test >= 0) report_test(cur_test, test_cmds, errors - errs_at_start);
        cur_test = tr_test[i];
        test_cmds = 0;
        errs_at_start = errors;
      end
      run_command(i);
      test_cmds++;
    end
    if (cur_test >= 0) report_test(cur_test, test_cmds, errors - errs_at_start);
    $display("done: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog, bound grows with the trace length
  initial begin
    wait (loaded);
    repeat ((n_lines + 1) * CYCLES_PER_LINE + 8) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles",
             (n_lines + 1) * CYCLES_PER_LINE + 8);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/ll_pkg.sv
hw/ll_node_mem.sv
hw/ll_free_list.sv
hw/ll_walker.sv
hw/ll_ctrl_fsm.sv
hw/ll_mngr_top.sv
bench/ll_mngr_props.sv
bench/tb_ll_mngr.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_ll_mngr
FILELIST  = build.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/ll_trace.txt */
# test op list pos data(hex) exp_status exp_data(hex)
# op 0 add_head 1 add_tail 2 del_head 3 read_pos 4 read_count 5 read_total, status 0 ok 1 empty 2 full 3 bad_pos
1 1 1 0 000a 0 0000
1 1 1 0 000b 0 0000
1 0 1 0 000c 0 0000
1 0 1 0 000d 0 0000
1 3 1 0 0000 0 000d
1 3 1 1 0000 0 000c
1 3 1 2 0000 0 000a
1 3 1 3 0000 0 000b
2 2 1 0 0000 0 000d
2 3 1 0 0000 0 000c
2 3 1 2 0000 0 000b
2 2 0 0 0000 1 0000
3 4 1 0 0000 0 0003
3 4 0 0 0000 0 0000
3 5 0 0 0000 0 0003
4 3 1 3 0000 3 0000
4 3 1 9 0000 3 0000
4 3 2 0 0000 1 0000
5 1 0 0 0010 0 0000
5 0 2 0 0020 0 0000
5 1 3 0 0030 0 0000
5 1 0 0 0011 0 0000
5 0 2 0 0021 0 0000
5 1 3 0 0031 0 0000
5 0 0 0 0012 0 0000
5 0 2 0 0022 0 0000
5 1 3 0 0032 0 0000
5 1 0 0 0013 0 0000
5 1 2 0 0023 0 0000
5 0 3 0 0033 0 0000
5 1 1 0 000e 0 0000
5 5 0 0 0000 0 0010
5 0 0 0 0099 2 0000
5 5 0 0 0000 0 0010
5 2 2 0 0000 0 0022
5 1 2 0 0024 0 0000
5 5 0 0 0000 0 0010
6 3 0 1 0000 0 0010
6 3 0 3 0000 0 0013
6 3 2 0 0000 0 0021
6 3 2 3 0000 0 0024
6 3 3 0 0000 0 0033
6 3 3 3 0000 0 0032
6 4 3 0 0000 0 0004
6 3 1 3 0000 0 000e
6 4 0 0 0000 0 0004
